/* common/rv_macros.svh */
// ==========================================================
// Core-wide widths, start address and major opcodes
// ==========================================================
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// Datapath and register file geometry
`define RV_XLEN        32
`define RV_REG_ADDR_W  5
`define RV_NUM_REGS    32
`define RV_STRB_W      4

// Fetch
`define RV_RESET_PC    32'h0000_0000
`define RV_PC_STEP     32'd4

// Major opcodes of the kept instruction groups
`define RV_OPC_OP      7'b0110011   // Register-register ALU
`define RV_OPC_OP_IMM  7'b0010011   // Register-immediate ALU
`define RV_OPC_STORE   7'b0100011   // SB, SH, SW

`endif

/* common/rv_pkg.sv */
// ==========================================================
// Shared types of the pipeline
// Words, register indices, byte strobes, operation codes
// ==========================================================
`include "rv_macros.svh"

package rv_pkg;

    // Data word or byte address
    typedef logic [`RV_XLEN-1:0] word_t;

    // Index into the register file
    typedef logic [`RV_REG_ADDR_W-1:0] reg_addr_t;

    // One bit per byte lane of a store
    typedef logic [`RV_STRB_W-1:0] strobe_t;

    // ALU operation, shared by R-type, I-type and address calculation
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_e;

    // Store access width
    typedef enum logic [1:0] {
        MEM_BYTE,
        MEM_HALF,
        MEM_WORD
    } mem_size_e;

endpackage

/* common/decoded_op_if.sv */
// ==========================================================
// Decoded operation from decode into execute
// ==========================================================
`timescale 1ns/1ps

interface decoded_op_if import rv_pkg::*; ();

    alu_op_e   alu_op;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     imm;
    logic      use_imm;     // Operand B from imm
    logic      reg_write;
    logic      mem_write;
    mem_size_e mem_size;

    modport producer (
        output alu_op, rs1, rs2, rd, rs1_data, rs2_data, imm,
        output use_imm, reg_write, mem_write, mem_size
    );

    modport consumer (
        input alu_op, rs1, rs2, rd, rs1_data, rs2_data, imm,
        input use_imm, reg_write, mem_write, mem_size
    );

endinterface

/* common/exec_result_if.sv */
// ==========================================================
// Executed operation from the EX/MEM register to memory
// ==========================================================
`timescale 1ns/1ps

interface exec_result_if import rv_pkg::*; ();

    word_t     result;      // ALU result or store address
    word_t     store_data;
    reg_addr_t rd;
    logic      reg_write;
    logic      mem_write;
    mem_size_e mem_size;

    // Execute also reads its own outputs back for forwarding
    modport producer (
        output result, store_data, rd,
        output reg_write, mem_write, mem_size
    );

    modport consumer (
        input result, store_data, rd,
        input reg_write, mem_write, mem_size
    );

endinterface

/* rtl/reg_file.sv */
// ==========================================================
// Register file, 32 words, x0 reads as zero
// Write-through bypass to both read ports
// ==========================================================
`timescale 1ns/1ps
`include "rv_macros.svh"

module reg_file import rv_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    output word_t     rs1_data,
    output word_t     rs2_data,
    input  logic      wb_en,
    input  reg_addr_t wb_rd,
    input  word_t     wb_data
);

    word_t regs [`RV_NUM_REGS];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `RV_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // Same-cycle write wins over the stored value
    function automatic word_t read_port(input reg_addr_t addr);
        if (addr == '0)
            return '0;
        if (wb_en && wb_rd == addr)
            return wb_data;
        return regs[addr];
    endfunction

    always_comb begin
        rs1_data = read_port(rs1);
        rs2_data = read_port(rs2);
    end

endmodule

/* rtl/decode_stage/decode_stage.sv */
// ==========================================================
// Fetch and decode stage
// PC, IF/ID register, decoder, immediates, register read
// ==========================================================
`timescale 1ns/1ps
`include "rv_macros.svh"

module decode_stage import rv_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  word_t      imem_data,
    output word_t      imem_addr,
    decoded_op_if.producer op,
    input  logic       wb_en,
    input  reg_addr_t  wb_rd,
    input  word_t      wb_data
);

    word_t pc;
    word_t instr_q;             // IF/ID
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t imm_i;
    word_t imm_s;

    // ======================================================
    // Fetch
    // ======================================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc      <= `RV_RESET_PC;
            instr_q <= '0;      // Opcode 0 decodes as no-op
        end else begin
            pc      <= pc + `RV_PC_STEP;
            instr_q <= imem_data;
        end
    end

    assign imem_addr = pc;

    // ======================================================
    // Decode
    // ======================================================
    assign opcode = instr_q[6:0];
    assign funct3 = instr_q[14:12];
    assign funct7 = instr_q[31:25];

    assign op.rd  = instr_q[11:7];
    assign op.rs1 = instr_q[19:15];
    assign op.rs2 = instr_q[24:20];

    // Sign-extended I-type and S-type immediates
    assign imm_i = {{20{instr_q[31]}}, instr_q[31:20]};
    assign imm_s = {{20{instr_q[31]}}, instr_q[31:25], instr_q[11:7]};

    always_comb begin
        op.alu_op    = ALU_ADD;
        op.imm       = imm_i;
        op.use_imm   = 1'b0;
        op.reg_write = 1'b0;
        op.mem_write = 1'b0;
        op.mem_size  = MEM_WORD;
        case (opcode)
            `RV_OPC_OP: begin
                op.reg_write = 1'b1;
                case ({funct7, funct3})
                    {7'h00, 3'b000}: op.alu_op = ALU_ADD;
                    {7'h20, 3'b000}: op.alu_op = ALU_SUB;
                    {7'h00, 3'b111}: op.alu_op = ALU_AND;
                    {7'h00, 3'b110}: op.alu_op = ALU_OR;
                    {7'h00, 3'b100}: op.alu_op = ALU_XOR;
                    {7'h00, 3'b010}: op.alu_op = ALU_SLT;
                    default:         op.reg_write = 1'b0;
                endcase
            end
            `RV_OPC_OP_IMM: begin
                op.reg_write = 1'b1;
                op.use_imm   = 1'b1;
                case (funct3)
                    3'b000:  op.alu_op = ALU_ADD;
                    3'b111:  op.alu_op = ALU_AND;
                    3'b110:  op.alu_op = ALU_OR;
                    3'b100:  op.alu_op = ALU_XOR;
                    3'b010:  op.alu_op = ALU_SLT;
                    default: op.reg_write = 1'b0;   // Shifts not supported
                endcase
            end
            `RV_OPC_STORE: begin
                op.imm       = imm_s;
                op.use_imm   = 1'b1;   // Address is rs1 + imm
                op.mem_write = 1'b1;
                case (funct3)
                    3'b000:  op.mem_size = MEM_BYTE;
                    3'b001:  op.mem_size = MEM_HALF;
                    3'b010:  op.mem_size = MEM_WORD;
                    default: op.mem_write = 1'b0;
                endcase
            end
            default: op.reg_write = 1'b0;
        endcase
    end

    // Register read with writeback bypass
    reg_file u_reg_file (
        .clk      (clk),
        .reset    (reset),
        .rs1      (op.rs1),
        .rs2      (op.rs2),
        .rs1_data (op.rs1_data),
        .rs2_data (op.rs2_data),
        .wb_en    (wb_en),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data)
    );

endmodule

/* rtl/execute_stage/execute_stage.sv */
// ==========================================================
// Execute stage
// ID/EX register, operand forwarding, ALU, EX/MEM register
// ==========================================================
`timescale 1ns/1ps

module execute_stage import rv_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    decoded_op_if.consumer  op,
    exec_result_if.producer res,
    input  logic      wb_en,
    input  reg_addr_t wb_rd,
    input  word_t     wb_data
);

    // ID/EX contents
    alu_op_e   ex_alu_op;
    reg_addr_t ex_rs1;
    reg_addr_t ex_rs2;
    reg_addr_t ex_rd;
    word_t     ex_rs1_data;
    word_t     ex_rs2_data;
    word_t     ex_imm;
    logic      ex_use_imm;
    logic      ex_reg_write;
    logic      ex_mem_write;
    mem_size_e ex_mem_size;

    logic  mem_hit_a, mem_hit_b;
    logic  wb_hit_a, wb_hit_b;
    word_t fwd_a, fwd_b;
    word_t operand_b;
    word_t alu_result;

    // ======================================================
    // ID/EX register
    // ======================================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ex_reg_write <= 1'b0;
            ex_mem_write <= 1'b0;
        end else begin
            ex_reg_write <= op.reg_write;
            ex_mem_write <= op.mem_write;
        end
    end

    always_ff @(posedge clk) begin
        ex_alu_op   <= op.alu_op;
        ex_rs1      <= op.rs1;
        ex_rs2      <= op.rs2;
        ex_rd       <= op.rd;
        ex_rs1_data <= op.rs1_data;
        ex_rs2_data <= op.rs2_data;
        ex_imm      <= op.imm;
        ex_use_imm  <= op.use_imm;
        ex_mem_size <= op.mem_size;
    end

    // ======================================================
    // Forwarding, memory stage first, then writeback
    // ======================================================
    assign mem_hit_a = res.reg_write && (res.rd != '0) && (res.rd == ex_rs1);
    assign mem_hit_b = res.reg_write && (res.rd != '0) && (res.rd == ex_rs2);
    assign wb_hit_a  = wb_en && (wb_rd != '0) && (wb_rd == ex_rs1);
    assign wb_hit_b  = wb_en && (wb_rd != '0) && (wb_rd == ex_rs2);

    assign fwd_a = mem_hit_a ? res.result : (wb_hit_a ? wb_data : ex_rs1_data);
    assign fwd_b = mem_hit_b ? res.result : (wb_hit_b ? wb_data : ex_rs2_data);

    assign operand_b = ex_use_imm ? ex_imm : fwd_b;

    // ALU
    always_comb begin
        case (ex_alu_op)
            ALU_ADD: alu_result = fwd_a + operand_b;
            ALU_SUB: alu_result = fwd_a - operand_b;
            ALU_AND: alu_result = fwd_a & operand_b;
            ALU_OR:  alu_result = fwd_a | operand_b;
            ALU_XOR: alu_result = fwd_a ^ operand_b;
            ALU_SLT: alu_result = word_t'($signed(fwd_a) < $signed(operand_b));
            default: alu_result = '0;
        endcase
    end

    // ======================================================
    // EX/MEM register
    // ======================================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            res.reg_write <= 1'b0;
            res.mem_write <= 1'b0;
        end else begin
            res.reg_write <= ex_reg_write;
            res.mem_write <= ex_mem_write;
        end
    end

    always_ff @(posedge clk) begin
        res.result     <= alu_result;
        res.store_data <= fwd_b;        // Forwarded rs2 for stores
        res.rd         <= ex_rd;
        res.mem_size   <= ex_mem_size;
    end

endmodule

/* rtl/memory_stage/memory_stage.sv */
// ==========================================================
// Memory stage
// Store lane alignment and strobes, MEM/WB register
// ==========================================================
`timescale 1ns/1ps

module memory_stage import rv_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    exec_result_if.consumer res,
    output word_t     dmem_addr,
    output word_t     dmem_wdata,
    output strobe_t   dmem_wstrb,
    output logic      dmem_wr,
    output logic      wb_en,
    output reg_addr_t wb_rd,
    output word_t     wb_data
);

    strobe_t lane_strb;

    // ======================================================
    // Store formatting
    // ======================================================
    always_comb begin
        case (res.mem_size)
            MEM_BYTE: begin
                dmem_wdata = word_t'(res.store_data[7:0]) << {res.result[1:0], 3'b000};
                lane_strb  = strobe_t'(1) << res.result[1:0];
            end
            MEM_HALF: begin
                if (res.result[1]) begin
                    dmem_wdata = {res.store_data[15:0], 16'h0000};
                    lane_strb  = 4'b1100;
                end else begin
                    dmem_wdata = {16'h0000, res.store_data[15:0]};
                    lane_strb  = 4'b0011;
                end
            end
            default: begin      // Word
                dmem_wdata = res.store_data;
                lane_strb  = 4'b1111;
            end
        endcase
    end

    assign dmem_addr  = res.result;
    assign dmem_wr    = res.mem_write;
    assign dmem_wstrb = res.mem_write ? lane_strb : '0;   // Quiet between stores

    // ======================================================
    // MEM/WB register
    // ======================================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb_en <= 1'b0;
        end else begin
            wb_en <= res.reg_write;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd   <= res.rd;
        wb_data <= res.result;
    end

endmodule

/* rtl/rv_core_top.sv */
// ==========================================================
// Five-stage integer core for a reduced RV32I subset
// ==========================================================
`timescale 1ns/1ps

module rv_core_top import rv_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  word_t   imem_data,
    output word_t   imem_addr,
    output word_t   dmem_addr,
    output word_t   dmem_wdata,
    output strobe_t dmem_wstrb,
    output logic    dmem_wr
);

    // Writeback bus back to decode and execute
    logic      wb_en;
    reg_addr_t wb_rd;
    word_t     wb_data;

    decoded_op_if  dec_op ();
    exec_result_if ex_res ();

    decode_stage u_decode (
        .clk       (clk),
        .reset     (reset),
        .imem_data (imem_data),
        .imem_addr (imem_addr),
        .op        (dec_op.producer),
        .wb_en     (wb_en),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data)
    );

    execute_stage u_execute (
        .clk     (clk),
        .reset   (reset),
        .op      (dec_op.consumer),
        .res     (ex_res.producer),
        .wb_en   (wb_en),
        .wb_rd   (wb_rd),
        .wb_data (wb_data)
    );

    memory_stage u_memory (
        .clk        (clk),
        .reset      (reset),
        .res        (ex_res.consumer),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_wstrb (dmem_wstrb),
        .dmem_wr    (dmem_wr),
        .wb_en      (wb_en),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data)
    );

endmodule

/* test/rv_core_properties.sv */
// ==========================================================
// Port assertions bound into the core top level
// ==========================================================
`timescale 1ns/1ps

module rv_core_properties import rv_pkg::*; (
    input logic    clk,
    input logic    reset,
    input word_t   imem_addr,
    input strobe_t dmem_wstrb,
    input logic    dmem_wr
);

    int assert_failures = 0;    // Read by the testbench top

    // Strobes only while a store is on the port
    strobe_matches_wr: assert property (@(posedge clk) disable iff (reset)
        (dmem_wstrb != '0) == dmem_wr)
    else begin
        $error("dmem_wstrb and dmem_wr disagree");
        assert_failures++;
    end

    // One word per cycle, no stalls
    fetch_steps_by_four: assert property (@(posedge clk) disable iff (reset)
        !$past(reset) |-> imem_addr == $past(imem_addr) + 32'd4)
    else begin
        $error("imem_addr did not advance by 4");
        assert_failures++;
    end

    reset_is_quiet: assert property (@(posedge clk)
        reset |-> (imem_addr == '0) && !dmem_wr && (dmem_wstrb == '0))
    else begin
        $error("core ports not idle during reset");
        assert_failures++;
    end

endmodule

bind rv_core_top rv_core_properties props_i (
    .clk        (clk),
    .reset      (reset),
    .imem_addr  (imem_addr),
    .dmem_wstrb (dmem_wstrb),
    .dmem_wr    (dmem_wr)
);

/* test/tb_checker.sv */
// ==========================================================
// Instruction-set model and scoreboard for the core ports
// ==========================================================
`timescale 1ns/1ps
`include "rv_macros.svh"

module tb_checker import rv_pkg::*; #(
    parameter int prog_len = 200
) (
    input  logic    clk,
    input  logic    reset,
    input  word_t   imem_data,
    input  word_t   imem_addr,
    input  word_t   dmem_addr,
    input  word_t   dmem_wdata,
    input  strobe_t dmem_wstrb,
    input  logic    dmem_wr,
    output logic    checks_done,
    output int      check_count,
    output int      error_count
);

    typedef struct packed {
        int      due;       // Edge after which the store sits on the port
        word_t   addr;
        word_t   data;
        strobe_t strb;
        logic    is_word;
    } store_t;

    localparam int t_reset = 0;
    localparam int t_fetch = 1;
    localparam int t_word = 2;
    localparam int t_sub = 3;
    localparam int t_timing = 4;

    string  test_names [5];
    int     test_checks [5];
    int     test_errors [5];
    word_t  model_regs [32];
    store_t expected [$];
    int     edge_count;

    initial begin
        test_names = '{"reset_state", "fetch_sequence", "word_stores",
                       "subword_stores", "store_timing"};
        for (int i = 0; i < 5; i++) begin
            test_checks[i] = 0;
            test_errors[i] = 0;
        end
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        edge_count  = 0;
        checks_done = 1'b0;
        check_count = 0;
        error_count = 0;
    end

    task automatic check_value(input int test, input string what,
                               input word_t exp_val, input word_t act_val);
        test_checks[test]++;
        if (exp_val !== act_val) begin
            test_errors[test]++;
            $display("[FAIL] %s %s expected %h actual %h",
                     test_names[test], what, exp_val, act_val);
        end
    endtask

    task automatic report_test(input int test);
        $display("%-15s %0d checks, %0d errors", test_names[test],
                 test_checks[test], test_errors[test]);
    endtask

    // Byte lanes selected by a strobe
    function automatic word_t lane_mask(input strobe_t s);
        return {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
    endfunction

    // ======================================================
    // Reference model, one instruction per capture edge
    // ======================================================
    task automatic run_model(input word_t instr, input int edge_idx);
        word_t  a;
        word_t  b;
        word_t  res;
        logic   wr;
        store_t st;
        a   = model_regs[instr[19:15]];
        b   = model_regs[instr[24:20]];
        res = '0;
        wr  = 1'b1;
        if (instr[6:0] == `RV_OPC_OP && instr[31:25] == 7'h20 && instr[14:12] == 3'd0) begin
            res = a - b;
        end else if ((instr[6:0] == `RV_OPC_OP && instr[31:25] == 7'h00)
                     || instr[6:0] == `RV_OPC_OP_IMM) begin
            if (instr[6:0] == `RV_OPC_OP_IMM)
                b = {{20{instr[31]}}, instr[31:20]};
            case (instr[14:12])
                3'd0:    res = a + b;
                3'd7:    res = a & b;
                3'd6:    res = a | b;
                3'd4:    res = a ^ b;
                3'd2:    res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                default: wr = 1'b0;
            endcase
        end else begin
            wr = 1'b0;
            if (instr[6:0] == `RV_OPC_STORE && instr[14:12] <= 3'd2) begin
                st.due     = edge_idx + 2;
                st.addr    = a + {{20{instr[31]}}, instr[31:25], instr[11:7]};
                st.is_word = (instr[14:12] == 3'd2);
                case (instr[14:12])
                    3'd0:    st.strb = 4'b0001 << st.addr[1:0];
                    3'd1:    st.strb = st.addr[1] ? 4'b1100 : 4'b0011;
                    default: st.strb = 4'b1111;
                endcase
                case (instr[14:12])
                    3'd0:    st.data = {4{b[7:0]}} & lane_mask(st.strb);
                    3'd1:    st.data = {2{b[15:0]}} & lane_mask(st.strb);
                    default: st.data = b;
                endcase
                expected.push_back(st);
            end
        end
        if (wr && instr[11:7] != 5'd0)
            model_regs[instr[11:7]] = res;   // x0 stays zero
    endtask

    task automatic finish_checks();
        if (expected.size() != 0) begin
            test_errors[t_timing] += expected.size();
            $display("Stores missing at end of run, %0d never appeared", expected.size());
        end
        for (int t = 1; t < 5; t++) begin
            report_test(t);
            check_count += test_checks[t];
            error_count += test_errors[t];
        end
        check_count += test_checks[t_reset];
        error_count += test_errors[t_reset];
        checks_done = 1'b1;
    endtask

    // ======================================================
    // Capture side, sampled on the rising edge
    // ======================================================
    always @(posedge clk) begin
        if (!reset) begin
            check_value(t_fetch, "imem_addr", word_t'(edge_count * 4), imem_addr);
            if (edge_count == 0) begin
                check_value(t_reset, "imem_addr after release", '0, imem_addr);
                check_value(t_reset, "dmem_wr after release", '0, word_t'(dmem_wr));
                check_value(t_reset, "dmem_wstrb after release", '0, word_t'(dmem_wstrb));
                report_test(t_reset);
            end
            run_model(imem_data, edge_count);
            edge_count++;
        end
    end

    // Store side, sampled mid-cycle where the ports are stable
    always @(negedge clk) begin
        store_t st;
        if (reset) begin
            check_value(t_reset, "imem_addr", '0, imem_addr);
            check_value(t_reset, "dmem_wr", '0, word_t'(dmem_wr));
            check_value(t_reset, "dmem_wstrb", '0, word_t'(dmem_wstrb));
        end else if (edge_count > 0 && !checks_done) begin
            if (expected.size() > 0 && expected[0].due == edge_count - 1) begin
                st = expected.pop_front();
                check_value(t_timing, "dmem_wr", 32'd1, word_t'(dmem_wr));
                check_value(st.is_word ? t_word : t_sub, "dmem_addr", st.addr, dmem_addr);
                check_value(st.is_word ? t_word : t_sub, "dmem_wdata", st.data, dmem_wdata);
                check_value(st.is_word ? t_word : t_sub, "dmem_wstrb",
                            word_t'(st.strb), word_t'(dmem_wstrb));
            end else begin
                check_value(t_timing, "dmem_wr", '0, word_t'(dmem_wr));
            end
            if (edge_count >= prog_len + 3)
                finish_checks();
        end
    end

endmodule

/* test/tb_top.sv */
// ==========================================================
// Testbench top for the five-stage core
// Random program, instruction port and run summary
// ==========================================================
`timescale 1ns/1ps
`include "rv_macros.svh"

module tb_top import rv_pkg::*; ();

    localparam int    prog_len     = 200;
    localparam int    reset_cycles = 8;
    localparam int    cycle_limit  = reset_cycles + prog_len + 20;
    localparam word_t nop_word     = 32'h0000_0013;   // ADDI x0, x0, 0

    logic    clk;
    logic    reset;
    word_t   imem_data;
    word_t   imem_addr;
    word_t   dmem_addr;
    word_t   dmem_wdata;
    strobe_t dmem_wstrb;
    logic    dmem_wr;

    word_t program_mem [prog_len];
    word_t lcg_state;
    int    cycle_count = 0;
    logic  timed_out = 1'b0;
    logic  checks_done;
    int    check_count;
    int    error_count;
    int    total_errors;

    // Operation tables, index 1 of the register table is SUB
    logic [2:0] r_funct3 [6] = '{3'd0, 3'd0, 3'd7, 3'd6, 3'd4, 3'd2};
    logic [2:0] i_funct3 [5] = '{3'd0, 3'd7, 3'd6, 3'd4, 3'd2};

    rv_core_top rv_core_i (
        .clk        (clk),
        .reset      (reset),
        .imem_data  (imem_data),
        .imem_addr  (imem_addr),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_wstrb (dmem_wstrb),
        .dmem_wr    (dmem_wr)
    );

    tb_checker #(.prog_len(prog_len)) check_i (
        .clk         (clk),
        .reset       (reset),
        .imem_data   (imem_data),
        .imem_addr   (imem_addr),
        .dmem_addr   (dmem_addr),
        .dmem_wdata  (dmem_wdata),
        .dmem_wstrb  (dmem_wstrb),
        .dmem_wr     (dmem_wr),
        .checks_done (checks_done),
        .check_count (check_count),
        .error_count (error_count)
    );

    // LCG, upper half of the state
    function automatic word_t next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    // ======================================================
    // Program, about a third stores, registers x0 to x7
    // ======================================================
    task automatic build_program();
        int          kind;
        int          sel;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        logic [11:0] imm;
        lcg_state = 32'd13;
        for (int i = 0; i < prog_len; i++) begin
            kind = int'(next_random() % 3);
            sel  = int'(next_random() % 6);
            rd   = reg_addr_t'(next_random() % 8);    // Small set for dense hazards
            rs1  = reg_addr_t'(next_random() % 8);
            rs2  = reg_addr_t'(next_random() % 8);
            imm  = 12'(next_random());
            case (kind)
                0: program_mem[i] = {imm[11:5], rs2, rs1, 3'(sel % 3), imm[4:0],
                                     `RV_OPC_STORE};
                1: program_mem[i] = {(sel == 1) ? 7'h20 : 7'h00, rs2, rs1,
                                     r_funct3[sel], rd, `RV_OPC_OP};
                default: program_mem[i] = {imm, rs1, i_funct3[sel % 5], rd, `RV_OPC_OP_IMM};
            endcase
        end
    endtask

    function automatic word_t word_at(input word_t addr);
        if ((addr >> 2) < prog_len)
            return program_mem[addr[9:2]];
        return nop_word;    // Past the end of the program
    endfunction

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Instruction port
    always @(negedge clk) begin
        imem_data <= word_at(imem_addr);
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count + 1 >= cycle_limit)
            timed_out <= 1'b1;
    end

    initial begin
        reset     <= 1'b1;
        imem_data = nop_word;
        build_program();
        repeat (reset_cycles) @(negedge clk);
        reset <= 1'b0;
        wait (checks_done || timed_out);
        total_errors = error_count + rv_core_i.props_i.assert_failures;
        $display("Run ended after %0d cycles with %0d checks and %0d errors",
                 cycle_count, check_count, total_errors);
        if (!checks_done) begin
            $display("Timeout, the checker did not finish within %0d cycles", cycle_limit);
            $display("TEST FAILED");
        end else if (total_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+common
common/rv_pkg.sv
common/decoded_op_if.sv
common/exec_result_if.sv
rtl/reg_file.sv
rtl/decode_stage/decode_stage.sv
rtl/execute_stage/execute_stage.sv
rtl/memory_stage/memory_stage.sv
rtl/rv_core_top.sv
test/rv_core_properties.sv
test/tb_checker.sv
test/tb_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the core and its testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_top -f build.f -o tb_sim \
    || { echo "Build failed"; exit 1; }

./obj_dir/tb_sim | tee /dev/stderr | grep -x "TEST OK" > /dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
